/* mic_array.f */
logic/mic_array_pkg.sv
logic/mic_capture.sv
logic/hann_window.sv
logic/pdm_modulator.sv
logic/frame_energy.sv
logic/source_localizer.sv
logic/mic_array_top.sv
bench/mic_source_model.sv
bench/mic_array_tb.sv

/* bench/mic_array_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_array_tb
  import mic_array_pkg::*;
();

  // clk_m cycles per word-select period and per frame
  localparam int WORD_CYCLES  = 2 * WS_BITS * SCK_DIV;
  localparam int FRAME_CYCLES = FRAME_LEN * WORD_CYCLES;

  logic                 clk_m = 1'b0;
  logic                 sys_rst;
  logic [NUM_MICS-1:0]  sel;
  wire  [NUM_MICS-1:0]  mic_data;
  wire                  mic_sck;
  wire                  mic_ws;
  wire                  spk;
  wire  [ANGLE_W-1:0]   angle;
  wire  [ENERGY_W-1:0]  peak_energy;
  wire                  angle_valid;

  // rounded half window
  int          hann_half [FRAME_LEN/2];
  // samples sent in the frame under test by mic and index
  int          frame_smp [NUM_MICS][FRAME_LEN];
  logic [31:0] rng_state;

  mic_array_top dut0 (
    .clk_m       (clk_m),
    .sys_rst     (sys_rst),
    .sel         (sel),
    .mic_data    (mic_data),
    .mic_sck     (mic_sck),
    .mic_ws      (mic_ws),
    .spk         (spk),
    .angle       (angle),
    .peak_energy (peak_energy),
    .angle_valid (angle_valid)
  );

  mic_source_model mic_source_model (
    .clk_m    (clk_m),
    .mic_sck  (mic_sck),
    .mic_ws   (mic_ws),
    .mic_data (mic_data)
  );

  always #20 clk_m = ~clk_m;

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  // 32767 * sin^2(pi*n/63) for n = 0..31
  task automatic build_hann_table();
    real s;
    for (int n = 0; n < FRAME_LEN/2; n++) begin
      s = $sin(3.14159265358979 * n / (FRAME_LEN - 1));
      hann_half[n] = $rtoi(32767.0 * s * s + 0.5);
    end
  endtask

  // upper half mirrors to 63-n
  function automatic int hann_coef(input int n);
    if (n < FRAME_LEN/2) begin
      return hann_half[n];
    end
    return hann_half[FRAME_LEN-1-n];
  endfunction

  function automatic longint windowed(input int smp, input int n);
    longint prod;
    prod = longint'(smp) * longint'(hann_coef(n));
    return prod >>> (COEF_W - 1);
  endfunction

  function automatic longint channel_energy(input int ch);
    longint sum;
    longint w;
    sum = 0;
    for (int n = 0; n < FRAME_LEN; n++) begin
      w = windowed(frame_smp[ch][n], n);
      sum += w * w;
    end
    return sum;
  endfunction

  // equal energies keep the lower index
  function automatic int loudest_channel();
    int best;
    best = 0;
    for (int i = 1; i < NUM_MICS; i++) begin
      if (channel_energy(i) > channel_energy(best)) begin
        best = i;
      end
    end
    return best;
  endfunction

  // xorshift32
  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare and wait helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_angle(input string name, input logic [ANGLE_W-1:0] expected,
                             input logic [ANGLE_W-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s: angle expected %0d, got %0d", name, expected, actual));
    end
  endtask

  task automatic check_energy(input string name, input logic [ENERGY_W-1:0] expected,
                              input logic [ENERGY_W-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("[FAIL] %s: energy expected %0d, got %0d", name, expected, actual));
    end
  endtask

  task automatic check_count(input string name, input int expected, input int actual,
                             input int tol);
    int diff;
    diff = (actual > expected) ? actual - expected : expected - actual;
    if (diff > tol) begin
      abort_run($sformatf("[FAIL] %s: expected %0d, got %0d", name, expected, actual));
    end
  endtask

  // returns on the falling edge where the pulse is high
  task automatic wait_angle_valid(input string name, output int waited);
    waited = 0;
    do begin
      @(negedge clk_m);
      waited++;
      if (waited > 2 * FRAME_CYCLES) begin
        abort_run($sformatf("%s: no angle_valid pulse within %0d cycles", name,
                            2 * FRAME_CYCLES));
      end
    end while (angle_valid !== 1'b1);
  endtask

  task automatic wait_ws_fall(input string name);
    logic prev;
    int   n;
    n = 0;
    do begin
      prev = mic_ws;
      @(negedge clk_m);
      n++;
      if (n > 2 * WORD_CYCLES) begin
        abort_run($sformatf("%s: mic_ws did not fall within %0d cycles", name,
                            2 * WORD_CYCLES));
      end
    end while (!(prev === 1'b1 && mic_ws === 1'b0));
  endtask

  task automatic load_constant(input int w0, input int w1, input int w2, input int w3);
    for (int n = 0; n < FRAME_LEN; n++) begin
      frame_smp[0][n] = w0;
      frame_smp[1][n] = w1;
      frame_smp[2][n] = w2;
      frame_smp[3][n] = w3;
    end
    mic_source_model.set_words(SAMPLE_W'(w0), SAMPLE_W'(w1), SAMPLE_W'(w2), SAMPLE_W'(w3));
  endtask

  // one loud mic over a quiet floor
  task automatic load_loud(input int ch);
    load_constant((ch == 0) ? 10000 : 1500, (ch == 1) ? 10000 : 1500,
                  (ch == 2) ? 10000 : 1500, (ch == 3) ? 10000 : 1500);
  endtask

  task automatic send_words(input int n);
    mic_source_model.set_words(SAMPLE_W'(frame_smp[0][n]), SAMPLE_W'(frame_smp[1][n]),
                               SAMPLE_W'(frame_smp[2][n]), SAMPLE_W'(frame_smp[3][n]));
  endtask

  task automatic expect_bearing(input string name, input int ch, output int waited);
    wait_angle_valid(name, waited);
    check_angle(name, ANGLE_W'(ch * SECTOR_DEG), angle);
    check_energy(name, ENERGY_W'(channel_energy(ch)), peak_energy);
  endtask

  task automatic count_spk_ones(output int ones);
    ones = 0;
    for (int i = 0; i < (1 << SAMPLE_W); i++) begin
      @(negedge clk_m);
      if (spk === 1'b1) begin
        ones++;
      end
    end
  endtask

  task automatic check_idle_outputs(input string name);
    check_count({name, " spk"}, 0, (spk === 1'b0) ? 0 : 1, 0);
    check_count({name, " angle_valid"}, 0, (angle_valid === 1'b0) ? 0 : 1, 0);
    check_count({name, " mic_ws"}, 0, (mic_ws === 1'b0) ? 0 : 1, 0);
    check_count({name, " mic_sck"}, 0, (mic_sck === 1'b0) ? 0 : 1, 0);
    check_angle(name, '0, angle);
    check_energy(name, '0, peak_energy);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    sys_rst = 1'b1;
    repeat (8) @(negedge clk_m);
    check_idle_outputs("reset held");
    repeat (8) @(negedge clk_m);
    sys_rst = 1'b0;
    @(negedge clk_m);
    check_idle_outputs("reset released");
  endtask

  task automatic single_loud_channel();
    int waited;
    load_constant(0, 0, 12000, 0);
    // frame in flight may hold older words
    wait_angle_valid("single loud sync", waited);
    expect_bearing("single loud", 2, waited);
  endtask

  task automatic random_samples();
    logic [31:0] r;
    int          waited;
    for (int n = 0; n < FRAME_LEN; n++) begin
      for (int ch = 0; ch < NUM_MICS; ch++) begin
        r = next_random();
        // mic 3 at full scale and the others at an eighth
        if (ch == NUM_MICS - 1) begin
          frame_smp[ch][n] = int'($signed(r[SAMPLE_W-1:0]));
        end else begin
          frame_smp[ch][n] = int'($signed(r[SAMPLE_W-1:0])) >>> 3;
        end
      end
    end
    wait_angle_valid("random sync", waited);
    send_words(0);
    for (int n = 0; n < FRAME_LEN; n++) begin
      wait_ws_fall("random slot");
      // model took the word on the edge just seen
      @(negedge clk_m);
      if (n < FRAME_LEN - 1) begin
        send_words(n + 1);
      end
    end
    expect_bearing("random samples", loudest_channel(), waited);
  endtask

  task automatic tie_rule();
    int waited;
    load_constant(0, 9000, 0, 9000);
    wait_angle_valid("tie sync", waited);
    expect_bearing("tie rule", 1, waited);
  endtask

  task automatic playback_density();
    int ones;
    int lvl0;
    int lvl2;
    lvl0 = -1500;
    lvl2 = 5000;
    load_constant(lvl0, 700, lvl2, -300);
    sel = 4'b0100;
    // one full slot so the new words reach the sample buses
    wait_ws_fall("playback settle");
    wait_ws_fall("playback settle");
    count_spk_ones(ones);
    check_count("playback mic 2", lvl2 + (1 << (SAMPLE_W - 1)), ones, 1);
    // no switch set falls back to mic 0
    sel = 4'b0000;
    @(negedge clk_m);
    count_spk_ones(ones);
    check_count("playback mic 0", lvl0 + (1 << (SAMPLE_W - 1)), ones, 1);
  endtask

  task automatic consecutive_frames();
    int loud [3];
    int waited;
    loud[0] = 3;
    loud[1] = 0;
    loud[2] = 1;
    load_loud(loud[0]);
    wait_angle_valid("consecutive sync", waited);
    for (int f = 0; f < 3; f++) begin
      expect_bearing($sformatf("consecutive frame %0d", f), loud[f], waited);
      // frames run back to back with no gap
      if (f > 0) begin
        check_count("consecutive spacing", FRAME_CYCLES, waited, 0);
      end
      if (f < 2) begin
        load_loud(loud[f + 1]);
      end
    end
  endtask

  initial begin
    sys_rst   = 1'b1;
    sel       = '0;
    rng_state = 32'd94;
    build_hann_table();
    reset_state();
    single_loud_channel();
    random_samples();
    tie_rule();
    playback_density();
    consecutive_frames();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* bench/mic_source_model.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_source_model
  import mic_array_pkg::*;
(
  input  wire                  clk_m,
  input  wire                  mic_sck,
  input  wire                  mic_ws,
  output logic [NUM_MICS-1:0]  mic_data
);

  // word queued for the next slot, and the word on the lines now
  logic [SAMPLE_W-1:0] next_word [NUM_MICS];
  logic [SAMPLE_W-1:0] cur_word  [NUM_MICS];
  logic                sck_q = 1'b0;
  logic                ws_q  = 1'b0;
  // bit on the lines, -1 once the word is out
  int                  bit_pos = SAMPLE_W - 1;

  // taken at the next falling edge of mic_ws
  task automatic set_words(
    input logic [SAMPLE_W-1:0] w0,
    input logic [SAMPLE_W-1:0] w1,
    input logic [SAMPLE_W-1:0] w2,
    input logic [SAMPLE_W-1:0] w3
  );
    next_word[0] = w0;
    next_word[1] = w1;
    next_word[2] = w2;
    next_word[3] = w3;
  endtask

  initial begin
    for (int i = 0; i < NUM_MICS; i++) begin
      next_word[i] = '0;
      cur_word[i]  = '0;
    end
    mic_data = '0;
  end

  // sck and ws seen half a clk_m period late, so lines move on the falling edge
  always @(negedge clk_m) begin
    if (sck_q === 1'b1 && mic_sck === 1'b0) begin
      if (ws_q === 1'b1 && mic_ws === 1'b0) begin
        // new low slot, msb goes out first
        for (int i = 0; i < NUM_MICS; i++) begin
          cur_word[i] = next_word[i];
        end
        bit_pos = SAMPLE_W - 1;
      end else if (bit_pos >= 0) begin
        bit_pos = bit_pos - 1;
      end
    end
    sck_q = mic_sck;
    ws_q  = mic_ws;
    for (int i = 0; i < NUM_MICS; i++) begin
      if (mic_ws === 1'b0 && bit_pos >= 0) begin
        mic_data[i] <= cur_word[i][bit_pos];
      end else begin
        mic_data[i] <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mic_array_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_array_top
  import mic_array_pkg::*;
(
  input  wire                  clk_m,
  input  wire                  sys_rst,
  input  wire  [NUM_MICS-1:0]  sel,
  input  wire  [NUM_MICS-1:0]  mic_data,
  output logic                 mic_sck,
  output logic                 mic_ws,
  output logic                 spk,
  output logic [ANGLE_W-1:0]   angle,
  output logic [ENERGY_W-1:0]  peak_energy,
  output logic                 angle_valid
);

  logic signed [SAMPLE_W-1:0] mic0_data;
  logic signed [SAMPLE_W-1:0] mic1_data;
  logic signed [SAMPLE_W-1:0] mic2_data;
  logic signed [SAMPLE_W-1:0] mic3_data;
  logic                       sample_valid;
  logic signed [SAMPLE_W-1:0] win0;
  logic signed [SAMPLE_W-1:0] win1;
  logic signed [SAMPLE_W-1:0] win2;
  logic signed [SAMPLE_W-1:0] win3;
  logic                       win_valid;
  logic                       win_last;
  logic [ENERGY_W-1:0]        energy0;
  logic [ENERGY_W-1:0]        energy1;
  logic [ENERGY_W-1:0]        energy2;
  logic [ENERGY_W-1:0]        energy3;
  logic                       frame_done;
  logic signed [SAMPLE_W-1:0] playback;
  logic                       pdm_out;

  //////////////////////////////////////////////////////////////////////
  // capture and playback
  //////////////////////////////////////////////////////////////////////
  mic_capture u_capture (
    .clk_m        (clk_m),
    .sys_rst      (sys_rst),
    .mic_data     (mic_data),
    .mic_sck      (mic_sck),
    .mic_ws       (mic_ws),
    .mic0_data    (mic0_data),
    .mic1_data    (mic1_data),
    .mic2_data    (mic2_data),
    .mic3_data    (mic3_data),
    .sample_valid (sample_valid)
  );

  // lowest set switch wins, mic 0 when none set
  always_comb begin
    if (sel[0]) begin
      playback = mic0_data;
    end else if (sel[1]) begin
      playback = mic1_data;
    end else if (sel[2]) begin
      playback = mic2_data;
    end else if (sel[3]) begin
      playback = mic3_data;
    end else begin
      playback = mic0_data;
    end
  end

  pdm_modulator u_pdm (
    .clk_m   (clk_m),
    .sys_rst (sys_rst),
    .level   (playback),
    .pdm_out (pdm_out)
  );

  assign spk = pdm_out;

  //////////////////////////////////////////////////////////////////////
  // window, energy, bearing
  //////////////////////////////////////////////////////////////////////

  // sample_valid -> win_valid -> frame_done -> angle_valid, one cycle each
  hann_window u_window (
    .clk_m        (clk_m),
    .sys_rst      (sys_rst),
    .mic0_data    (mic0_data),
    .mic1_data    (mic1_data),
    .mic2_data    (mic2_data),
    .mic3_data    (mic3_data),
    .sample_valid (sample_valid),
    .win0         (win0),
    .win1         (win1),
    .win2         (win2),
    .win3         (win3),
    .win_valid    (win_valid),
    .win_last     (win_last)
  );

  frame_energy u_energy (
    .clk_m      (clk_m),
    .sys_rst    (sys_rst),
    .win0       (win0),
    .win1       (win1),
    .win2       (win2),
    .win3       (win3),
    .win_valid  (win_valid),
    .win_last   (win_last),
    .energy0    (energy0),
    .energy1    (energy1),
    .energy2    (energy2),
    .energy3    (energy3),
    .frame_done (frame_done)
  );

  source_localizer u_localizer (
    .clk_m       (clk_m),
    .sys_rst     (sys_rst),
    .energy0     (energy0),
    .energy1     (energy1),
    .energy2     (energy2),
    .energy3     (energy3),
    .frame_done  (frame_done),
    .angle       (angle),
    .peak_energy (peak_energy),
    .angle_valid (angle_valid)
  );

endmodule

`default_nettype wire

/* logic/source_localizer.sv */
`timescale 1ns/1ps
`default_nettype none

module source_localizer
  import mic_array_pkg::*;
(
  input  wire                  clk_m,
  input  wire                  sys_rst,
  input  wire  [ENERGY_W-1:0]  energy0,
  input  wire  [ENERGY_W-1:0]  energy1,
  input  wire  [ENERGY_W-1:0]  energy2,
  input  wire  [ENERGY_W-1:0]  energy3,
  input  wire                  frame_done,
  output logic [ANGLE_W-1:0]   angle,
  output logic [ENERGY_W-1:0]  peak_energy,
  output logic                 angle_valid
);

  logic                pick_hi01;
  logic                pick_hi23;
  logic                pick_hi;
  logic [ENERGY_W-1:0] best01;
  logic [ENERGY_W-1:0] best23;
  logic [ENERGY_W-1:0] best;
  logic [1:0]          best_idx;

  //////////////////////////////////////////////////////////////////////
  // two-level compare tree
  //////////////////////////////////////////////////////////////////////

  // strict greater-than everywhere, so equal values keep the lower index
  always_comb begin
    pick_hi01 = energy1 > energy0;
    best01    = pick_hi01 ? energy1 : energy0;
    pick_hi23 = energy3 > energy2;
    best23    = pick_hi23 ? energy3 : energy2;
    // pair 2/3 only wins when strictly louder than pair 0/1
    pick_hi   = best23 > best01;
    best      = pick_hi ? best23 : best01;
    best_idx  = pick_hi ? {1'b1, pick_hi23} : {1'b0, pick_hi01};
  end

  // bearing is mic position times sector size
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      angle       <= '0;
      peak_energy <= '0;
      angle_valid <= 1'b0;
    end else begin
      angle_valid <= frame_done;
      if (frame_done) begin
        angle       <= ANGLE_W'(best_idx) * ANGLE_W'(SECTOR_DEG);
        peak_energy <= best;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/frame_energy.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_energy
  import mic_array_pkg::*;
(
  input  wire                         clk_m,
  input  wire                         sys_rst,
  input  wire  signed [SAMPLE_W-1:0]  win0,
  input  wire  signed [SAMPLE_W-1:0]  win1,
  input  wire  signed [SAMPLE_W-1:0]  win2,
  input  wire  signed [SAMPLE_W-1:0]  win3,
  input  wire                         win_valid,
  input  wire                         win_last,
  output logic [ENERGY_W-1:0]         energy0,
  output logic [ENERGY_W-1:0]         energy1,
  output logic [ENERGY_W-1:0]         energy2,
  output logic [ENERGY_W-1:0]         energy3,
  output logic                        frame_done
);

  logic signed [SAMPLE_W-1:0]   win_arr [NUM_MICS];
  logic signed [2*SAMPLE_W-1:0] prod    [NUM_MICS];
  logic [ENERGY_W-1:0]          sq      [NUM_MICS];
  logic [ENERGY_W-1:0]          acc     [NUM_MICS];
  // running sum including the sample on the inputs now
  logic [ENERGY_W-1:0]          total   [NUM_MICS];
  logic                         frame_end;

  assign frame_end = win_valid && win_last;

  always_comb begin
    win_arr[0] = win0;
    win_arr[1] = win1;
    win_arr[2] = win2;
    win_arr[3] = win3;
    for (int i = 0; i < NUM_MICS; i++) begin
      // square is never negative, even for -32768
      prod[i]  = win_arr[i] * win_arr[i];
      sq[i]    = ENERGY_W'($unsigned(prod[i]));
      total[i] = acc[i] + sq[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // per-channel accumulators
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      for (int i = 0; i < NUM_MICS; i++) begin
        acc[i] <= '0;
      end
    end else if (win_valid) begin
      for (int i = 0; i < NUM_MICS; i++) begin
        // last sample goes to the outputs, next frame starts at zero
        acc[i] <= win_last ? '0 : total[i];
      end
    end
  end

  // frame totals, held until the next frame end
  always_ff @(posedge clk_m) begin
    if (frame_end) begin
      energy0 <= total[0];
      energy1 <= total[1];
      energy2 <= total[2];
      energy3 <= total[3];
    end
  end

  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      frame_done <= 1'b0;
    end else begin
      frame_done <= frame_end;
    end
  end

endmodule

`default_nettype wire

/* logic/pdm_modulator.sv */
`timescale 1ns/1ps
`default_nettype none

module pdm_modulator
  import mic_array_pkg::*;
(
  input  wire                         clk_m,
  input  wire                         sys_rst,
  input  wire  signed [SAMPLE_W-1:0]  level,
  output logic                        pdm_out
);

  // residue carried between cycles
  logic [SAMPLE_W-1:0] acc;
  // offset binary, -32768 maps to 0
  logic [SAMPLE_W-1:0] level_u;
  logic [SAMPLE_W:0]   sum;

  assign level_u = {~level[SAMPLE_W-1], level[SAMPLE_W-2:0]};
  assign sum     = {1'b0, acc} + {1'b0, level_u};

  //////////////////////////////////////////////////////////////////////
  // first-order sigma-delta
  //////////////////////////////////////////////////////////////////////

  // carry out is the density bit, ones per 2^16 cycles track level_u
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      acc     <= '0;
      pdm_out <= 1'b0;
    end else begin
      acc     <= sum[SAMPLE_W-1:0];
      pdm_out <= sum[SAMPLE_W];
    end
  end

endmodule

`default_nettype wire

/* logic/hann_window.sv */
`timescale 1ns/1ps
`default_nettype none

module hann_window
  import mic_array_pkg::*;
(
  input  wire                         clk_m,
  input  wire                         sys_rst,
  input  wire  signed [SAMPLE_W-1:0]  mic0_data,
  input  wire  signed [SAMPLE_W-1:0]  mic1_data,
  input  wire  signed [SAMPLE_W-1:0]  mic2_data,
  input  wire  signed [SAMPLE_W-1:0]  mic3_data,
  input  wire                         sample_valid,
  output logic signed [SAMPLE_W-1:0]  win0,
  output logic signed [SAMPLE_W-1:0]  win1,
  output logic signed [SAMPLE_W-1:0]  win2,
  output logic signed [SAMPLE_W-1:0]  win3,
  output logic                        win_valid,
  output logic                        win_last
);

  logic [IDX_W-1:0]               idx;
  logic [IDX_W-2:0]               rom_addr;
  logic [COEF_W-1:0]              coef;
  logic signed [COEF_W:0]         coef_s;
  logic signed [SAMPLE_W-1:0]     smp  [NUM_MICS];
  logic signed [SAMPLE_W+COEF_W:0] prod [NUM_MICS];

  // second half of the frame reads the table backwards, 63-n
  assign rom_addr = idx[IDX_W-1] ? ~idx[IDX_W-2:0] : idx[IDX_W-2:0];

  // round(32767 * sin^2(pi*n/63)), n = 0..31
  always_comb begin
    case (rom_addr)
      5'd0:  coef = 16'd0;
      5'd1:  coef = 16'd81;
      5'd2:  coef = 16'd325;
      5'd3:  coef = 16'd728;
      5'd4:  coef = 16'd1286;
      5'd5:  coef = 16'd1995;
      5'd6:  coef = 16'd2847;
      5'd7:  coef = 16'd3833;
      5'd8:  coef = 16'd4944;
      5'd9:  coef = 16'd6169;
      5'd10: coef = 16'd7495;
      5'd11: coef = 16'd8909;
      5'd12: coef = 16'd10398;
      5'd13: coef = 16'd11946;
      5'd14: coef = 16'd13539;
      5'd15: coef = 16'd15159;
      5'd16: coef = 16'd16792;
      5'd17: coef = 16'd18421;
      5'd18: coef = 16'd20029;
      5'd19: coef = 16'd21601;
      5'd20: coef = 16'd23122;
      5'd21: coef = 16'd24575;
      5'd22: coef = 16'd25947;
      5'd23: coef = 16'd27224;
      5'd24: coef = 16'd28393;
      5'd25: coef = 16'd29443;
      5'd26: coef = 16'd30363;
      5'd27: coef = 16'd31145;
      5'd28: coef = 16'd31779;
      5'd29: coef = 16'd32260;
      5'd30: coef = 16'd32584;
      default: coef = 16'd32747;
    endcase
  end

  // coefficient is unsigned, zero bit on top keeps the multiply signed
  assign coef_s = {1'b0, coef};

  always_comb begin
    smp[0] = mic0_data;
    smp[1] = mic1_data;
    smp[2] = mic2_data;
    smp[3] = mic3_data;
    for (int i = 0; i < NUM_MICS; i++) begin
      prod[i] = smp[i] * coef_s;
    end
  end

  // one shared coefficient, four products, >>> 15 by bit select
  always_ff @(posedge clk_m) begin
    if (sample_valid) begin
      win0 <= prod[0][SAMPLE_W+COEF_W-2:COEF_W-1];
      win1 <= prod[1][SAMPLE_W+COEF_W-2:COEF_W-1];
      win2 <= prod[2][SAMPLE_W+COEF_W-2:COEF_W-1];
      win3 <= prod[3][SAMPLE_W+COEF_W-2:COEF_W-1];
    end
  end

  // sample index and frame flags
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      idx       <= '0;
      win_valid <= 1'b0;
      win_last  <= 1'b0;
    end else begin
      win_valid <= sample_valid;
      win_last  <= sample_valid && (idx == FRAME_LEN - 1);
      if (sample_valid) begin
        if (idx == FRAME_LEN - 1) begin
          idx <= '0;
        end else begin
          idx <= idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mic_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module mic_capture
  import mic_array_pkg::*;
(
  input  wire                         clk_m,
  input  wire                         sys_rst,
  input  wire  [NUM_MICS-1:0]         mic_data,
  output logic                        mic_sck,
  output logic                        mic_ws,
  output logic signed [SAMPLE_W-1:0]  mic0_data,
  output logic signed [SAMPLE_W-1:0]  mic1_data,
  output logic signed [SAMPLE_W-1:0]  mic2_data,
  output logic signed [SAMPLE_W-1:0]  mic3_data,
  output logic                        sample_valid
);

  // divider phase inside one bit clock
  logic [$clog2(SCK_DIV)-1:0]   div_cnt;
  // bit clock index inside one word-select period
  logic [$clog2(2*WS_BITS)-1:0] bit_cnt;
  logic                         sck_rise;
  logic                         sck_end;
  logic                         capture;
  logic                         word_done;
  logic [SAMPLE_W-2:0]          shreg [NUM_MICS];
  logic [SAMPLE_W-1:0]          word  [NUM_MICS];

  // edge that takes sck high
  assign sck_rise  = (div_cnt == SCK_DIV/2 - 1);
  assign sck_end   = (div_cnt == SCK_DIV - 1);
  assign mic_sck   = (div_cnt >= SCK_DIV/2);
  // low half first, so a full slot follows reset
  assign mic_ws    = (bit_cnt >= WS_BITS);
  // msb first, bits past SAMPLE_W in the slot are ignored
  assign capture   = sck_rise && (bit_cnt < SAMPLE_W);
  assign word_done = sck_rise && (bit_cnt == SAMPLE_W - 1);

  // current shift contents plus the bit on the line
  always_comb begin
    for (int i = 0; i < NUM_MICS; i++) begin
      word[i] = {shreg[i], mic_data[i]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bit clock and word select
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (sck_end) begin
      div_cnt <= '0;
      if (bit_cnt == 2*WS_BITS - 1) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // data lines move on the falling edge, stable two cycles later
  always_ff @(posedge clk_m) begin
    if (capture) begin
      for (int i = 0; i < NUM_MICS; i++) begin
        shreg[i] <= word[i][SAMPLE_W-2:0];
      end
    end
  end

  // bit 0 arrives, all four words land together
  always_ff @(posedge clk_m) begin
    if (sys_rst) begin
      sample_valid <= 1'b0;
      mic0_data    <= '0;
      mic1_data    <= '0;
      mic2_data    <= '0;
      mic3_data    <= '0;
    end else begin
      sample_valid <= word_done;
      if (word_done) begin
        mic0_data <= word[0];
        mic1_data <= word[1];
        mic2_data <= word[2];
        mic3_data <= word[3];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mic_array_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// shared constants for the four-mic capture and localizer
//////////////////////////////////////////////////////////////////////

package mic_array_pkg;

  // array geometry
  localparam int NUM_MICS   = 4;
  // one position per quarter turn
  localparam int SECTOR_DEG = 90;

  // serial mic timing
  // clk_m cycles per bit clock, sck high in the second half
  localparam int SCK_DIV    = 4;
  // bit clocks per word-select half
  localparam int WS_BITS    = 32;
  localparam int SAMPLE_W   = 16;

  // analysis frame
  localparam int FRAME_LEN  = 64;
  localparam int IDX_W      = 6;
  // unsigned window gain, 32767 is unity
  localparam int COEF_W     = 16;

  // result widths
  // 64 squares of 16-bit values need 37 bits, some headroom
  localparam int ENERGY_W   = 40;
  localparam int ANGLE_W    = 16;

endpackage

`default_nettype wire
